/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = mul16_tb
FILELIST  = mul16.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // Starts low and first rises half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* bench/mul16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mul16_tb
  import mul16_pkg::*;
();

  localparam int CLK_NS       = 40;
  localparam int RESET_CYC    = 8;
  localparam int SETTLE_CYC   = 10;
  localparam int DRAIN_LIMIT  = 6;
  localparam int SINGLE_CYC   = DRAIN_LIMIT + 2;
  localparam int CORNER_PAIRS = 6 + OP_W * OP_W;
  localparam int CARRY_PAIRS  = 5;
  localparam int STREAM_PAIRS = 200;
  localparam int GAP_PAIRS    = 100;
  localparam int MAX_GAP      = 3;
  localparam int MARGIN_CYC   = 100;
  // Worst case length of every test added up
  localparam int TOTAL_CYC = RESET_CYC + SETTLE_CYC
                           + (CORNER_PAIRS + CARRY_PAIRS) * SINGLE_CYC
                           + STREAM_PAIRS + SINGLE_CYC
                           + GAP_PAIRS * (MAX_GAP + 1) + SINGLE_CYC
                           + MARGIN_CYC;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  product_t exp_q[$];
  string    test_name = "init";
  int       err_value = 0;
  int       err_other = 0;
  int       seed = 32'ha5ad2c48;
  logic     iv_d1 = 1'b0;
  logic     iv_d2 = 1'b0;

  clk_gen #(.PERIOD_NS(CLK_NS)) i_clk_gen (.clk(clk));

  mul16_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  task automatic check_product(input string name, input product_t expected,
                               input product_t actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %h actual %h", name, expected, actual);
      err_value++;
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s: out_valid expected %b actual %b", name, expected, actual);
      err_value++;
    end
  endtask

  task automatic drive_pair(input operand_t a_val, input operand_t b_val);
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= a_val;
    b        <= b_val;
    exp_q.push_back(product_t'(a_val) * product_t'(b_val));
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    in_valid <= 1'b0;
    // Operands are junk while in_valid is low
    a        <= operand_t'($random(seed));
    b        <= operand_t'($random(seed));
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d result(s) never arrived", name, exp_q.size());
      err_other++;
      exp_q.delete();
    end
  endtask

  task automatic run_single(input string name, input operand_t a_val, input operand_t b_val);
    test_name = name;
    drive_pair(a_val, b_val);
    idle_cycle();
    wait_drain(name);
  endtask

  task automatic test_reset();
    test_name = "reset";
    for (int i = 0; i < RESET_CYC + SETTLE_CYC; i++) begin
      @(posedge clk);
      if (i == RESET_CYC - 1) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      check_valid("reset", 1'b0, out_valid);
    end
  endtask

  task automatic test_corners();
    string name;
    run_single("zero_a", 16'h0000, 16'hbeef);
    run_single("zero_b", 16'h1234, 16'h0000);
    run_single("zero_zero", 16'h0000, 16'h0000);
    run_single("one_a", 16'h0001, 16'hc3a5);
    run_single("one_b", 16'h7e01, 16'h0001);
    run_single("max_max", 16'hffff, 16'hffff);
    for (int i = 0; i < OP_W; i++) begin
      for (int j = 0; j < OP_W; j++) begin
        name = $sformatf("pow2_%0d_%0d", i, j);
        run_single(name, operand_t'(1) << i, operand_t'(1) << j);
      end
    end
  endtask

  // Partial products that carry from one quadrant into the next
  task automatic test_carries();
    run_single("carry_ll", 16'h00ff, 16'h00ff);
    run_single("carry_hl", 16'hff00, 16'h00ff);
    run_single("carry_lh", 16'h00ff, 16'hff00);
    run_single("carry_spread", 16'hffff, 16'h0101);
    run_single("carry_top", 16'h8000, 16'h8000);
  endtask

  task automatic run_stream(input string name, input int n_pairs, input int max_gap);
    int gap;
    test_name = name;
    for (int k = 0; k < n_pairs; k++) begin
      gap = int'($unsigned($random(seed)) % (max_gap + 1));
      repeat (gap) begin
        idle_cycle();
      end
      drive_pair(operand_t'($random(seed)), operand_t'($random(seed)));
    end
    idle_cycle();
    wait_drain(name);
  endtask

  // Compares out_valid with in_valid two cycles back and pops results in order
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      check_valid(test_name, iv_d2, out_valid);
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("%s: result arrived with no pair outstanding", test_name);
          err_other++;
        end else begin
          check_product(test_name, exp_q.pop_front(), product);
        end
      end
      iv_d2 = iv_d1;
      iv_d1 = in_valid;
    end
  end

  initial begin
    #(CLK_NS * TOTAL_CYC);
    $display("Timeout: tests still running after %0d cycles", TOTAL_CYC);
    err_other++;
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    a        <= '0;
    b        <= '0;
    test_reset();
    test_corners();
    test_carries();
    run_stream("back_to_back", STREAM_PAIRS, 0);
    run_stream("gapped", GAP_PAIRS, MAX_GAP);
    repeat (4) @(posedge clk);
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/array_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module array_mult #(
  parameter int WIDTH = 8
) (
  input  wire logic [WIDTH-1:0] x,
  input  wire logic [WIDTH-1:0] y,
  output logic [2*WIDTH-1:0]    p
);

  // pp[j] holds x AND y[j] at weight i+j for bit i
  wire [WIDTH-1:0] pp [WIDTH];
  // Running sums and saved carries of each adder row
  wire [WIDTH-1:0] s [WIDTH];
  wire [WIDTH-2:0] c [1:WIDTH-1];
  // Final ripple row
  wire [WIDTH-2:0] rs;
  wire [WIDTH-2:0] rc;

  genvar i, j;

  for (j = 0; j < WIDTH; j++) begin : g_pp
    assign pp[j] = x & {WIDTH{y[j]}};
  end

  assign s[0] = pp[0];

  for (j = 1; j < WIDTH; j++) begin : g_row
    // Top term of the row has nothing to add yet
    assign s[j][WIDTH-1] = pp[j][WIDTH-1];

    for (i = 0; i < WIDTH-1; i++) begin : g_col
      if (j == 1) begin : g_ha
        assign s[j][i] = s[j-1][i+1] ^ pp[j][i];
        assign c[j][i] = s[j-1][i+1] & pp[j][i];
      end else begin : g_fa
        assign s[j][i] = s[j-1][i+1] ^ pp[j][i] ^ c[j-1][i];
        assign c[j][i] = (s[j-1][i+1] & pp[j][i]) |
                         (c[j-1][i] & (s[j-1][i+1] ^ pp[j][i]));
      end
    end
  end

  // Low half falls out of the rows one bit at a time
  for (j = 0; j < WIDTH; j++) begin : g_low
    assign p[j] = s[j][0];
  end

  // Merge the last row's sums and carries
  assign rs[0] = s[WIDTH-1][1] ^ c[WIDTH-1][0];
  assign rc[0] = s[WIDTH-1][1] & c[WIDTH-1][0];

  for (i = 1; i < WIDTH-1; i++) begin : g_final
    assign rs[i] = s[WIDTH-1][i+1] ^ c[WIDTH-1][i] ^ rc[i-1];
    assign rc[i] = (s[WIDTH-1][i+1] & c[WIDTH-1][i]) |
                   (rc[i-1] & (s[WIDTH-1][i+1] ^ c[WIDTH-1][i]));
  end

  assign p[2*WIDTH-2:WIDTH] = rs;
  assign p[2*WIDTH-1]       = rc[WIDTH-2];

endmodule

`default_nettype wire

/* design/cla_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module cla_adder
  import mul16_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  wire logic [WIDTH-1:0] a,
  input  wire logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0]      sum
);

  // WIDTH must be a whole number of groups
  localparam int NGRP = WIDTH / GROUP_W;

  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;
  logic [WIDTH-1:0] c;
  logic [NGRP-1:0]  grp_p;
  logic [NGRP-1:0]  grp_g;
  logic [NGRP-1:0]  grp_c;

  assign p = a ^ b;
  assign g = a & b;

  // Group propagate/generate, then carries into each group
  always_comb begin
    logic term;
    for (int k = 0; k < NGRP; k++) begin
      grp_p[k] = &p[k*GROUP_W +: GROUP_W];
      grp_g[k] = 1'b0;
      for (int i = 0; i < GROUP_W; i++) begin
        term = g[k*GROUP_W + i];
        for (int m = i + 1; m < GROUP_W; m++) begin
          term = term & p[k*GROUP_W + m];
        end
        grp_g[k] = grp_g[k] | term;
      end
    end

    // Carry-in is zero, so only generate terms reach a group
    grp_c[0] = 1'b0;
    for (int k = 1; k < NGRP; k++) begin
      grp_c[k] = 1'b0;
      for (int m = 0; m < k; m++) begin
        term = grp_g[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & grp_p[n];
        end
        grp_c[k] = grp_c[k] | term;
      end
    end
  end

  // Lookahead inside each group from its incoming carry
  always_comb begin
    logic term;
    for (int k = 0; k < NGRP; k++) begin
      for (int i = 0; i < GROUP_W; i++) begin
        term = grp_c[k];
        for (int m = 0; m < i; m++) begin
          term = term & p[k*GROUP_W + m];
        end
        c[k*GROUP_W + i] = term;
        for (int j = 0; j < i; j++) begin
          term = g[k*GROUP_W + j];
          for (int m = j + 1; m < i; m++) begin
            term = term & p[k*GROUP_W + m];
          end
          c[k*GROUP_W + i] = c[k*GROUP_W + i] | term;
        end
      end
    end
  end

  // Top group carry out is never formed
  assign sum = p ^ c;

endmodule

`default_nettype wire

/* design/mul16_pkg.sv */
`default_nettype none

package mul16_pkg;

  // Operand half, full operand and product widths
  localparam int HALF_W = 8;
  localparam int OP_W   = 16;
  localparam int PROD_W = 32;

  // Bits per carry-lookahead group
  localparam int GROUP_W = 4;

  typedef logic [OP_W-1:0]     operand_t;
  typedef logic [HALF_W-1:0]   half_t;
  typedef logic [2*HALF_W-1:0] quad_prod_t;
  typedef logic [PROD_W-1:0]   product_t;

endpackage

`default_nettype wire

/* design/mul16_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mul16_top
  import mul16_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire logic     in_valid,
  input  wire operand_t a,
  input  wire operand_t b,
  output logic          out_valid,
  output product_t      product
);

  logic       quad_valid;
  quad_prod_t prod_ll;
  quad_prod_t prod_lh;
  quad_prod_t prod_hl;
  quad_prod_t prod_hh;

  // Stage 1 quadrant products
  quadrant_products #(
    .WIDTH (HALF_W)
  ) i_quad (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .a          (a),
    .b          (b),
    .quad_valid (quad_valid),
    .prod_ll    (prod_ll),
    .prod_lh    (prod_lh),
    .prod_hl    (prod_hl),
    .prod_hh    (prod_hh)
  );

  // Stage 2 alignment and lookahead sums
  product_sum #(
    .WIDTH (PROD_W)
  ) i_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .quad_valid (quad_valid),
    .prod_ll    (prod_ll),
    .prod_lh    (prod_lh),
    .prod_hl    (prod_hl),
    .prod_hh    (prod_hh),
    .out_valid  (out_valid),
    .product    (product)
  );

endmodule

`default_nettype wire

/* design/product_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module product_sum
  import mul16_pkg::*;
#(
  parameter int WIDTH = PROD_W
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire logic       quad_valid,
  input  wire quad_prod_t prod_ll,
  input  wire quad_prod_t prod_lh,
  input  wire quad_prod_t prod_hl,
  input  wire quad_prod_t prod_hh,
  output logic            out_valid,
  output product_t        product
);

  product_t llhh;
  product_t lh_ext;
  product_t hl_ext;
  product_t partial;
  product_t total;

  // hh and ll never overlap so they share one word
  assign llhh = {prod_hh, prod_ll};

  // Cross products sit HALF_W bits up
  assign lh_ext = {{HALF_W{1'b0}}, prod_lh, {HALF_W{1'b0}}};
  assign hl_ext = {{HALF_W{1'b0}}, prod_hl, {HALF_W{1'b0}}};

  cla_adder #(.WIDTH(WIDTH)) i_add_lh (
    .a   (llhh),
    .b   (lh_ext),
    .sum (partial)
  );

  cla_adder #(.WIDTH(WIDTH)) i_add_hl (
    .a   (partial),
    .b   (hl_ext),
    .sum (total)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= quad_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (quad_valid) begin
      product <= total;
    end
  end

endmodule

`default_nettype wire

/* design/quadrant_products.sv */
`timescale 1ns/1ps
`default_nettype none

module quadrant_products
  import mul16_pkg::*;
#(
  parameter int WIDTH = HALF_W
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire logic       in_valid,
  input  wire operand_t   a,
  input  wire operand_t   b,
  output logic            quad_valid,
  output quad_prod_t      prod_ll,
  output quad_prod_t      prod_lh,
  output quad_prod_t      prod_hl,
  output quad_prod_t      prod_hh
);

  half_t      a_lo;
  half_t      a_hi;
  half_t      b_lo;
  half_t      b_hi;
  quad_prod_t ll;
  quad_prod_t lh;
  quad_prod_t hl;
  quad_prod_t hh;

  assign a_lo = a[HALF_W-1:0];
  assign a_hi = a[OP_W-1:HALF_W];
  assign b_lo = b[HALF_W-1:0];
  assign b_hi = b[OP_W-1:HALF_W];

  // First letter names the half of a, second the half of b
  array_mult #(.WIDTH(WIDTH)) i_mult_ll (.x(a_lo), .y(b_lo), .p(ll));
  array_mult #(.WIDTH(WIDTH)) i_mult_lh (.x(a_lo), .y(b_hi), .p(lh));
  array_mult #(.WIDTH(WIDTH)) i_mult_hl (.x(a_hi), .y(b_lo), .p(hl));
  array_mult #(.WIDTH(WIDTH)) i_mult_hh (.x(a_hi), .y(b_hi), .p(hh));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      quad_valid <= 1'b0;
    end else begin
      quad_valid <= in_valid;
    end
  end

  // Hold products between pairs
  always_ff @(posedge clk) begin
    if (in_valid) begin
      prod_ll <= ll;
      prod_lh <= lh;
      prod_hl <= hl;
      prod_hh <= hh;
    end
  end

endmodule

`default_nettype wire

/* mul16.f */
design/mul16_pkg.sv
design/array_mult.sv
design/cla_adder.sv
design/quadrant_products.sv
design/product_sum.sv
design/mul16_top.sv
bench/clk_gen.sv
bench/mul16_tb.sv
